// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_difftest_top
FILELIST  := all.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulator prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+tests
src/core_pkg.sv
src/trace_pkg.sv
src/insn_shadow_pipe.sv
src/rob_alloc.sv
src/shadow_rob.sv
src/commit_trace_stage.sv
src/trace_ctrl_regs.sv
src/difftest_top.sv
tests/tb_difftest_top.sv

// ==== src/commit_trace_stage.sv ====
module commit_trace_stage #(
   parameter  int P_COMMIT = 1,
   localparam int CW = 1 << P_COMMIT
)
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [CW-1:0]                       cmt_fire,
   input  core_pkg::commit_lane_t [CW-1:0]     cmt_lane,
   input  core_pkg::insn_t [CW-1:0]            cmt_ins,
   input  core_pkg::commit_late_t [CW-1:0]     cmt_late,
   input  logic [trace_pkg::NUM_IRQ-1:0]       irq_irr,
   input  logic                                trace_en,
   output trace_pkg::commit_rec_t [CW-1:0]     trace,
   output trace_pkg::cnt_inc_t                 commit_cnt_inc
);

   logic [CW-1:0]                  fire_q;
   logic [CW-1:0]                  we_q;
   logic [CW-1:0]                  rec_valid;
   logic [core_pkg::PC_W-1:0]      pc_q [CW];
   core_pkg::insn_t [CW-1:0]       insn_q;
   logic [trace_pkg::NUM_IRQ-1:0]  irq_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fire_q <= '0;
         we_q <= '0;
      end
      else
      begin
         fire_q <= cmt_fire;
         for (int j = 0; j < CW; j++)
         begin
            we_q[j] <= cmt_fire[j] & cmt_lane[j].we;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int j = 0; j < CW; j++)
      begin
         pc_q[j] <= cmt_lane[j].pc;
      end
      insn_q <= cmt_ins;
      irq_q <= irq_irr;
   end

   assign rec_valid = fire_q & {CW{trace_en}};

   // Write address and data join from the late lane in the record cycle
   always_comb
   begin
      for (int j = 0; j < CW; j++)
      begin
         trace[j].valid = rec_valid[j];
         trace[j].pc = pc_q[j];
         trace[j].insn = insn_q[j];
         trace[j].we = we_q[j] & trace_en;
         trace[j].wnum = cmt_late[j].lrd;
         trace[j].wdata = cmt_late[j].lrd_dat;
         trace[j].irq = irq_q;
      end
   end

   assign commit_cnt_inc = trace_pkg::cnt_inc_t'($countones(rec_valid));

endmodule

// ==== src/core_pkg.sv ====
package core_pkg;

   localparam int INSN_W = 32;
   localparam int PC_W = 30;
   localparam int LRF_AW = 5;
   localparam int DATA_W = 32;

   typedef logic [INSN_W-1:0] insn_t;

   // Sized for the largest configuration of 4 banks by 16 entries
   typedef struct packed {
      logic [1:0] bank;
      logic [3:0] id;
   } rob_slot_t;

   // Sampled in the fire cycle
   typedef struct packed {
      logic [PC_W-1:0] pc;
      logic            we;
   } commit_lane_t;

   // Presented one cycle after fire
   typedef struct packed {
      logic [LRF_AW-1:0] lrd;
      logic [DATA_W-1:0] lrd_dat;
   } commit_late_t;

endpackage

// ==== src/difftest_top.sv ====
module difftest_top #(
   parameter  int P_ISSUE = 1,
   parameter  int P_COMMIT = 1,
   parameter  int P_ROB_DEPTH = 2,
   localparam int IW = 1 << P_ISSUE,
   localparam int CW = 1 << P_COMMIT
)
(
   input  logic                              clk,
   input  logic                              rst_n,
   // Decode and rename
   input  core_pkg::insn_t [IW-1:0]          id_ins,
   input  logic                              id_p_ce,
   input  logic                              rn_p_ce,
   // ROB push
   input  logic [P_ISSUE:0]                  push_size,
   output logic                              rob_ready,
   // Commit
   input  logic [CW-1:0]                     cmt_fire,
   input  core_pkg::commit_lane_t [CW-1:0]   cmt_lane,
   input  core_pkg::commit_late_t [CW-1:0]   cmt_late,
   input  logic [trace_pkg::NUM_IRQ-1:0]     irq_irr,
   output logic [CW-1:0]                     head_valid,
   output trace_pkg::commit_rec_t [CW-1:0]   trace,
   // Configuration port
   input  logic                              cfg_we,
   input  trace_pkg::reg_addr_e              cfg_addr,
   input  logic [trace_pkg::CFG_DW-1:0]      cfg_wdata,
   output logic [trace_pkg::CFG_DW-1:0]      cfg_rdata
);

   core_pkg::insn_t [IW-1:0]       issue_ins;
   core_pkg::rob_slot_t [IW-1:0]   free_slot;
   core_pkg::rob_slot_t [CW-1:0]   head_slot;
   core_pkg::insn_t [CW-1:0]       cmt_ins;
   logic                           trace_en;
   trace_pkg::cnt_inc_t            commit_cnt_inc;

   insn_shadow_pipe #(
      .P_ISSUE     (P_ISSUE)
   ) i_insn_shadow_pipe (
      .clk         (clk),
      .id_ins      (id_ins),
      .id_p_ce     (id_p_ce),
      .rn_p_ce     (rn_p_ce),
      .issue_ins   (issue_ins)
   );

   rob_alloc #(
      .P_ISSUE     (P_ISSUE),
      .P_COMMIT    (P_COMMIT),
      .P_ROB_DEPTH (P_ROB_DEPTH)
   ) i_rob_alloc (
      .clk         (clk),
      .rst_n       (rst_n),
      .push_size   (push_size),
      .cmt_fire    (cmt_fire),
      .free_slot   (free_slot),
      .head_slot   (head_slot),
      .head_valid  (head_valid),
      .rob_ready   (rob_ready)
   );

   shadow_rob #(
      .P_ISSUE     (P_ISSUE),
      .P_COMMIT    (P_COMMIT),
      .P_ROB_DEPTH (P_ROB_DEPTH)
   ) i_shadow_rob (
      .clk         (clk),
      .issue_ins   (issue_ins),
      .push_size   (push_size),
      .free_slot   (free_slot),
      .head_slot   (head_slot),
      .cmt_ins     (cmt_ins)
   );

   commit_trace_stage #(
      .P_COMMIT        (P_COMMIT)
   ) i_commit_trace_stage (
      .clk             (clk),
      .rst_n           (rst_n),
      .cmt_fire        (cmt_fire),
      .cmt_lane        (cmt_lane),
      .cmt_ins         (cmt_ins),
      .cmt_late        (cmt_late),
      .irq_irr         (irq_irr),
      .trace_en        (trace_en),
      .trace           (trace),
      .commit_cnt_inc  (commit_cnt_inc)
   );

   trace_ctrl_regs i_trace_ctrl_regs (
      .clk             (clk),
      .rst_n           (rst_n),
      .cfg_we          (cfg_we),
      .cfg_addr        (cfg_addr),
      .cfg_wdata       (cfg_wdata),
      .cfg_rdata       (cfg_rdata),
      .commit_cnt_inc  (commit_cnt_inc),
      .trace_en        (trace_en)
   );

endmodule

// ==== src/insn_shadow_pipe.sv ====
module insn_shadow_pipe #(
   parameter  int P_ISSUE = 1,
   localparam int IW = 1 << P_ISSUE
)
(
   input  logic                       clk,
   input  core_pkg::insn_t [IW-1:0]   id_ins,
   input  logic                       id_p_ce,
   input  logic                       rn_p_ce,
   output core_pkg::insn_t [IW-1:0]   issue_ins
);

   core_pkg::insn_t [IW-1:0] rn_ins;

   // Decode to rename
   always_ff @(posedge clk)
   begin
      if (id_p_ce)
      begin
         rn_ins <= id_ins;
      end
   end

   // Rename to issue
   always_ff @(posedge clk)
   begin
      if (rn_p_ce)
      begin
         issue_ins <= rn_ins;
      end
   end

endmodule

// ==== src/rob_alloc.sv ====
module rob_alloc #(
   parameter  int P_ISSUE = 1,
   parameter  int P_COMMIT = 1,
   parameter  int P_ROB_DEPTH = 2,
   localparam int IW = 1 << P_ISSUE,
   localparam int CW = 1 << P_COMMIT,
   localparam int DEPTH = 1 << P_ROB_DEPTH
)
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [P_ISSUE:0]               push_size,
   input  logic [CW-1:0]                  cmt_fire,
   output core_pkg::rob_slot_t [IW-1:0]   free_slot,
   output core_pkg::rob_slot_t [CW-1:0]   head_slot,
   output logic [CW-1:0]                  head_valid,
   output logic                           rob_ready
);

   typedef logic [P_COMMIT-1:0]    bank_t;
   typedef logic [P_ROB_DEPTH-1:0] idx_t;
   typedef logic [P_ROB_DEPTH:0]   cnt_t;

   bank_t tail_bank;
   bank_t head_bank;
   idx_t  wptr [CW];
   idx_t  rptr [CW];
   cnt_t  cnt [CW];

   // Lanes that map to each bank, for a full push and for this push
   int    need [CW];
   int    push_cnt [CW];
   logic [CW-1:0] pop_bank;

   always_comb
   begin
      bank_t b;
      for (int k = 0; k < CW; k++)
      begin
         need[k] = 0;
         push_cnt[k] = 0;
      end
      for (int i = 0; i < IW; i++)
      begin
         b = tail_bank + bank_t'(i);
         free_slot[i] = '0;
         free_slot[i].bank[P_COMMIT-1:0] = b;
         // Second lane into the same bank takes the next index
         free_slot[i].id[P_ROB_DEPTH-1:0] = wptr[b] + idx_t'(need[b]);
         need[b] = need[b] + 1;
         if (i < int'(push_size))
         begin
            push_cnt[b] = push_cnt[b] + 1;
         end
      end
   end

   always_comb
   begin
      bank_t b;
      pop_bank = '0;
      rob_ready = 1'b1;
      for (int j = 0; j < CW; j++)
      begin
         b = head_bank + bank_t'(j);
         head_slot[j] = '0;
         head_slot[j].bank[P_COMMIT-1:0] = b;
         head_slot[j].id[P_ROB_DEPTH-1:0] = rptr[b];
         head_valid[j] = (cnt[b] != '0);
         if (cmt_fire[j])
         begin
            pop_bank[b] = 1'b1;
         end
         if (DEPTH - int'(cnt[j]) < need[j])
         begin
            rob_ready = 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         tail_bank <= '0;
         head_bank <= '0;
         for (int k = 0; k < CW; k++)
         begin
            wptr[k] <= '0;
            rptr[k] <= '0;
            cnt[k] <= '0;
         end
      end
      else
      begin
         tail_bank <= tail_bank + bank_t'(push_size);
         head_bank <= head_bank + bank_t'($countones(cmt_fire));
         for (int k = 0; k < CW; k++)
         begin
            wptr[k] <= wptr[k] + idx_t'(push_cnt[k]);
            rptr[k] <= rptr[k] + idx_t'(pop_bank[k]);
            cnt[k] <= cnt[k] + cnt_t'(push_cnt[k]) - cnt_t'(pop_bank[k]);
         end
      end
   end

endmodule

// ==== src/shadow_rob.sv ====
module shadow_rob #(
   parameter  int P_ISSUE = 1,
   parameter  int P_COMMIT = 1,
   parameter  int P_ROB_DEPTH = 2,
   localparam int IW = 1 << P_ISSUE,
   localparam int CW = 1 << P_COMMIT,
   localparam int DEPTH = 1 << P_ROB_DEPTH
)
(
   input  logic                           clk,
   input  core_pkg::insn_t [IW-1:0]       issue_ins,
   input  logic [P_ISSUE:0]               push_size,
   input  core_pkg::rob_slot_t [IW-1:0]   free_slot,
   input  core_pkg::rob_slot_t [CW-1:0]   head_slot,
   output core_pkg::insn_t [CW-1:0]       cmt_ins
);

   core_pkg::insn_t mem [CW][DEPTH];

   // Only the lanes below push_size carry a real instruction
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < IW; i++)
      begin
         if (i < int'(push_size))
         begin
            mem[free_slot[i].bank[P_COMMIT-1:0]][free_slot[i].id[P_ROB_DEPTH-1:0]]
               <= issue_ins[i];
         end
      end
   end

   always_comb
   begin
      for (int j = 0; j < CW; j++)
      begin
         cmt_ins[j] = mem[head_slot[j].bank[P_COMMIT-1:0]][head_slot[j].id[P_ROB_DEPTH-1:0]];
      end
   end

endmodule

// ==== src/trace_ctrl_regs.sv ====
module trace_ctrl_regs
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         cfg_we,
   input  trace_pkg::reg_addr_e         cfg_addr,
   input  logic [trace_pkg::CFG_DW-1:0] cfg_wdata,
   output logic [trace_pkg::CFG_DW-1:0] cfg_rdata,
   input  trace_pkg::cnt_inc_t          commit_cnt_inc,
   output logic                         trace_en
);

   logic [trace_pkg::CFG_DW-1:0] commit_cnt;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         trace_en <= 1'b1;
         commit_cnt <= '0;
      end
      else
      begin
         if (cfg_we && cfg_addr == trace_pkg::REG_CTRL)
         begin
            trace_en <= cfg_wdata[trace_pkg::CTRL_EN_BIT];
         end
         // A write to REG_COUNT clears the counter
         if (cfg_we && cfg_addr == trace_pkg::REG_COUNT)
         begin
            commit_cnt <= '0;
         end
         else
         begin
            commit_cnt <= commit_cnt + trace_pkg::CFG_DW'(commit_cnt_inc);
         end
      end
   end

   always_comb
   begin
      cfg_rdata = '0;
      case (cfg_addr)
         trace_pkg::REG_CTRL:
         begin
            cfg_rdata[trace_pkg::CTRL_EN_BIT] = trace_en;
         end
         trace_pkg::REG_COUNT:
         begin
            cfg_rdata = commit_cnt;
         end
      endcase
   end

endmodule

// ==== src/trace_pkg.sv ====
package trace_pkg;

   localparam int NUM_IRQ = 8;
   localparam int CFG_DW = 32;

   // Enable bit within REG_CTRL
   localparam int CTRL_EN_BIT = 0;

   // Records per cycle, up to four commit lanes
   typedef logic [2:0] cnt_inc_t;

   typedef enum logic [0:0] {
      REG_CTRL  = 1'b0,
      REG_COUNT = 1'b1
   } reg_addr_e;

   typedef struct packed {
      logic                        valid;
      logic [core_pkg::PC_W-1:0]   pc;
      core_pkg::insn_t             insn;
      logic                        we;
      logic [core_pkg::LRF_AW-1:0] wnum;
      logic [core_pkg::DATA_W-1:0] wdata;
      logic [NUM_IRQ-1:0]          irq;
   } commit_rec_t;

endpackage

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Shadow ROB contents in program order, oldest first
core_pkg::insn_t rob_q [$];

function automatic core_pkg::insn_t pop_word();
   core_pkg::insn_t w;
   w = rob_q.pop_front();
   return w;
endfunction

// Expected record for one lane in the cycle after fire
function automatic trace_pkg::commit_rec_t make_record(input logic fired, input logic en,
   input core_pkg::commit_lane_t lane, input core_pkg::insn_t insn,
   input core_pkg::commit_late_t late, input irq_t irq);
   trace_pkg::commit_rec_t rec;
   rec.valid = fired & en;
   rec.pc = lane.pc;
   rec.insn = insn;
   rec.we = fired & lane.we & en;
   rec.wnum = late.lrd;
   rec.wdata = late.lrd_dat;
   rec.irq = irq;
   return rec;
endfunction

// Commit lane j sees the j-th oldest word
function automatic logic [CW-1:0] head_valid_expect(input int size);
   logic [CW-1:0] hv;
   for (int j = 0; j < CW; j++)
   begin
      hv[j] = (size > j);
   end
   return hv;
endfunction

// Every bank touched by a full push needs room for its lanes
function automatic logic ready_expect(input int size);
   int occ;
   int need;
   logic ready;
   ready = 1'b1;
   for (int k = 0; k < CW; k++)
   begin
      occ = (size + CW - 1 - k) / CW;
      need = 0;
      for (int i = 0; i < IW; i++)
      begin
         if ((size + i) % CW == k)
         begin
            need++;
         end
      end
      if (DEPTH - occ < need)
      begin
         ready = 1'b0;
      end
   end
   return ready;
endfunction

`endif

// ==== tests/tb_difftest_top.sv ====
module tb_difftest_top;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int P_ISSUE = 1;
   localparam int P_COMMIT = 1;
   localparam int P_ROB_DEPTH = 2;
   localparam int IW = 1 << P_ISSUE;
   localparam int CW = 1 << P_COMMIT;
   localparam int DEPTH = 1 << P_ROB_DEPTH;
   localparam int CLK_NS = 20;
   localparam int RESET_CYCLES = 10;
   localparam int PRIME_CYCLES = 2;
   localparam int SINGLE_CYCLES = 40;
   localparam int RANDOM_CYCLES = 300;
   localparam int IRQ_CYCLES = 40;
   localparam int EN_CYCLES = 30;
   localparam int FILL_LIMIT = 2 * DEPTH;
   localparam int DRAIN_LIMIT = 2 * DEPTH;
   localparam int FLUSH_CYCLES = 4;
   localparam int TOTAL_CYCLES = RESET_CYCLES + PRIME_CYCLES + SINGLE_CYCLES + RANDOM_CYCLES
      + IRQ_CYCLES + 3 * EN_CYCLES + 2 + FILL_LIMIT + DRAIN_LIMIT + 2 * FLUSH_CYCLES;
   localparam int WATCHDOG_NS = (TOTAL_CYCLES + 50) * CLK_NS;

   typedef logic [core_pkg::PC_W-1:0] pc_t;
   typedef logic [core_pkg::LRF_AW-1:0] lrd_t;
   typedef logic [trace_pkg::NUM_IRQ-1:0] irq_t;

   logic clk = 1'b0;
   logic rst_n;
   core_pkg::insn_t [IW-1:0] id_ins;
   logic id_p_ce;
   logic rn_p_ce;
   logic [P_ISSUE:0] push_size;
   logic rob_ready;
   logic [CW-1:0] cmt_fire;
   core_pkg::commit_lane_t [CW-1:0] cmt_lane;
   core_pkg::commit_late_t [CW-1:0] cmt_late;
   irq_t irq_irr;
   logic [CW-1:0] head_valid;
   trace_pkg::commit_rec_t [CW-1:0] trace;
   logic cfg_we;
   trace_pkg::reg_addr_e cfg_addr;
   logic [31:0] cfg_wdata;
   logic [31:0] cfg_rdata;

   `include "tb_ref_model.svh"

   string test_name;
   bit check_on;
   bit strobe_rand;
   logic [CW-1:0] exp_hv;
   logic exp_ready;
   logic [31:0] exp_cfg;
   trace_pkg::commit_rec_t exp_rec [CW];
   // Lane state captured in the fire cycle
   logic [CW-1:0] pend_fire;
   core_pkg::commit_lane_t pend_lane [CW];
   core_pkg::insn_t pend_insn [CW];
   irq_t pend_irq;
   logic pend_en;
   // Decode and issue stages as the words should stand
   core_pkg::insn_t [IW-1:0] m_rn;
   core_pkg::insn_t [IW-1:0] m_issue;
   logic model_en;
   int unsigned model_cnt;

   difftest_top #(
      .P_ISSUE     (P_ISSUE),
      .P_COMMIT    (P_COMMIT),
      .P_ROB_DEPTH (P_ROB_DEPTH)
   ) i_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .id_ins     (id_ins),
      .id_p_ce    (id_p_ce),
      .rn_p_ce    (rn_p_ce),
      .push_size  (push_size),
      .rob_ready  (rob_ready),
      .cmt_fire   (cmt_fire),
      .cmt_lane   (cmt_lane),
      .cmt_late   (cmt_late),
      .irq_irr    (irq_irr),
      .head_valid (head_valid),
      .trace      (trace),
      .cfg_we     (cfg_we),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata)
   );

   initial
   begin
      forever #(CLK_NS / 2) clk = ~clk;
   end

   task automatic report_mismatch(input string what, input logic [127:0] exp_v,
      input logic [127:0] act_v);
      $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first mismatch");
   endtask

   task automatic report_error(input string msg);
      $display("Error in %s: %s", test_name, msg);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic compare_outputs();
      assert (head_valid === exp_hv)
         else report_mismatch("head_valid", 128'(exp_hv), 128'(head_valid));
      assert (rob_ready === exp_ready)
         else report_mismatch("rob_ready", 128'(exp_ready), 128'(rob_ready));
      assert (cfg_rdata === exp_cfg)
         else report_mismatch("cfg_rdata", 128'(exp_cfg), 128'(cfg_rdata));
      for (int j = 0; j < CW; j++)
      begin
         assert (trace[j].valid === exp_rec[j].valid)
            else report_mismatch($sformatf("valid lane %0d", j), 128'(exp_rec[j].valid),
               128'(trace[j].valid));
         assert (trace[j].we === exp_rec[j].we)
            else report_mismatch($sformatf("we lane %0d", j), 128'(exp_rec[j].we),
               128'(trace[j].we));
         if (exp_rec[j].valid)
         begin
            assert (trace[j] === exp_rec[j])
               else report_mismatch($sformatf("record lane %0d", j), 128'(exp_rec[j]),
                  128'(trace[j]));
         end
      end
   endtask

   // One clock of stimulus, with push and fire clamped to what the ROB allows
   task automatic drive_cycle(input int n_push, input int n_fire, input logic ctrl_wr,
      input logic ctrl_val);
      int np;
      int nf;
      int size;
      logic en_next;
      logic id_ce;
      logic rn_ce;
      core_pkg::insn_t [IW-1:0] new_ins;
      core_pkg::commit_late_t late;
      core_pkg::commit_lane_t lane;
      irq_t irq;
      @(negedge clk);
      // Counter takes in the records of the cycle just ended
      for (int j = 0; j < CW; j++)
      begin
         if (exp_rec[j].valid)
         begin
            model_cnt++;
         end
      end
      for (int j = 0; j < CW; j++)
      begin
         late.lrd = lrd_t'($urandom);
         late.lrd_dat = $urandom;
         cmt_late[j] = late;
         exp_rec[j] = make_record(pend_fire[j], pend_en, pend_lane[j], pend_insn[j], late,
            pend_irq);
      end
      size = rob_q.size();
      exp_hv = head_valid_expect(size);
      exp_ready = ready_expect(size);
      exp_cfg = ctrl_wr ? 32'(model_en) : model_cnt;
      en_next = ctrl_wr ? ctrl_val : model_en;
      nf = (n_fire > size) ? size : n_fire;
      nf = (nf > CW) ? CW : nf;
      irq = irq_t'($urandom);
      irq_irr = irq;
      for (int j = 0; j < CW; j++)
      begin
         lane.pc = pc_t'($urandom);
         lane.we = 1'($urandom);
         cmt_lane[j] = lane;
         pend_lane[j] = lane;
         pend_fire[j] = (j < nf);
         pend_insn[j] = (j < nf) ? pop_word() : '0;
      end
      cmt_fire = CW'((1 << nf) - 1);
      pend_irq = irq;
      pend_en = en_next;
      np = exp_ready ? n_push : 0;
      np = (np > IW) ? IW : np;
      for (int i = 0; i < np; i++)
      begin
         rob_q.push_back(m_issue[i]);
      end
      push_size = np[P_ISSUE:0];
      id_ce = strobe_rand ? ($urandom % 4 != 0) : 1'b1;
      rn_ce = strobe_rand ? ($urandom % 4 != 0) : 1'b1;
      for (int i = 0; i < IW; i++)
      begin
         new_ins[i] = $urandom;
      end
      id_ins = new_ins;
      id_p_ce = id_ce;
      rn_p_ce = rn_ce;
      if (rn_ce)
      begin
         m_issue = m_rn;
      end
      if (id_ce)
      begin
         m_rn = new_ins;
      end
      cfg_we = ctrl_wr;
      cfg_addr = ctrl_wr ? trace_pkg::REG_CTRL : trace_pkg::REG_COUNT;
      cfg_wdata = ctrl_wr ? 32'(ctrl_val) : '0;
      model_en = en_next;
   endtask

   task automatic run_traffic(input int cycles, input int max_push, input int max_fire);
      for (int c = 0; c < cycles; c++)
      begin
         drive_cycle($urandom % (max_push + 1), $urandom % (max_fire + 1), 1'b0, 1'b0);
      end
   endtask

   // Records are checked a quarter period after the inputs change
   initial
   begin
      forever
      begin
         @(negedge clk);
         #(CLK_NS / 4);
         if (check_on)
         begin
            compare_outputs();
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout after %0d ns, the run did not reach its end", WATCHDOG_NS);
      $display("Test FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      int guard;
      void'($urandom(32'h50000b8c));
      rst_n = 1'b0;
      id_ins = '0;
      id_p_ce = 1'b0;
      rn_p_ce = 1'b0;
      push_size = '0;
      cmt_fire = '0;
      cmt_lane = '0;
      cmt_late = '0;
      irq_irr = '0;
      cfg_we = 1'b0;
      cfg_addr = trace_pkg::REG_COUNT;
      cfg_wdata = '0;
      check_on = 1'b0;
      strobe_rand = 1'b0;
      model_en = 1'b1;
      model_cnt = 0;
      m_rn = '0;
      m_issue = '0;
      pend_fire = '0;
      pend_en = 1'b1;
      pend_irq = '0;
      for (int j = 0; j < CW; j++)
      begin
         pend_lane[j] = '0;
         pend_insn[j] = '0;
         exp_rec[j] = make_record(1'b0, 1'b0, '0, '0, '0, '0);
      end
      exp_hv = '0;
      exp_ready = 1'b1;
      exp_cfg = '0;
      test_name = "reset";
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      check_on = 1'b1;

      // Both stages loaded before the first push
      test_name = "prime";
      repeat (PRIME_CYCLES) drive_cycle(0, 0, 1'b0, 1'b0);
      strobe_rand = 1'b1;

      test_name = "single_lane";
      run_traffic(SINGLE_CYCLES, 1, 1);
      test_name = "random_mix";
      run_traffic(RANDOM_CYCLES, IW, CW);
      test_name = "irq_change";
      run_traffic(IRQ_CYCLES, IW, CW);

      test_name = "trace_enable";
      run_traffic(EN_CYCLES, IW, CW);
      drive_cycle(IW, CW, 1'b1, 1'b0);
      run_traffic(EN_CYCLES, IW, CW);
      drive_cycle(IW, CW, 1'b1, 1'b1);
      run_traffic(EN_CYCLES, IW, CW);
      repeat (FLUSH_CYCLES) drive_cycle(0, 0, 1'b0, 1'b0);

      test_name = "fill_drain";
      guard = 0;
      while (rob_ready && guard < FILL_LIMIT)
      begin
         drive_cycle(IW, 0, 1'b0, 1'b0);
         guard++;
      end
      assert (!rob_ready)
         else report_error("rob_ready stayed high while the ROB was being filled");
      guard = 0;
      while (head_valid != '0 && guard < DRAIN_LIMIT)
      begin
         drive_cycle(0, CW, 1'b0, 1'b0);
         guard++;
      end
      assert (head_valid == '0 && rob_q.size() == 0)
         else report_error("head_valid did not clear when the ROB was drained");

      test_name = "final_flush";
      repeat (FLUSH_CYCLES) drive_cycle(0, 0, 1'b0, 1'b0);
      $display("Test OK");
      $finish;
   end

endmodule
